// File: src/pkt_pkg.sv
//-----------------------------------------------------------
// Shared widths, FIFO depth and stored word type for the
// packet filter. Modules refer to these by scoped names.
//-----------------------------------------------------------

package pkt_pkg;

  // Data word width
  localparam int DATA_W = 32;

  // Packet FIFO entries, must be a power of two
  localparam int FIFO_DEPTH = 64;

  // FIFO address width
  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  // Drop counter width, wraps on overflow
  localparam int CNT_W = 16;

  // Word as held in the FIFO and carried by the output stage
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } pkt_word_t;

endpackage

// File: src/pkt_checksum_check.sv
//-----------------------------------------------------------
// Input side of the packet filter. Keeps a running XOR over
// each packet and marks the last word when the checksum is
// wrong or the source flagged an error. Counts such packets.
// The data path is combinational to the FIFO.
//-----------------------------------------------------------

`timescale 1ns/1ps

module pkt_checksum_check (
  input  logic                      clk,
  input  logic                      i_arst_n,

  // From the source
  input  logic                      i_valid,
  input  logic [pkt_pkg::DATA_W-1:0] i_data,
  input  logic                      i_last,
  input  logic                      i_error,
  output logic                      o_ready,

  // Towards the packet FIFO
  output logic                      o_valid,
  output logic [pkt_pkg::DATA_W-1:0] o_data,
  output logic                      o_last,
  output logic                      o_error,
  input  logic                      i_ready,

  output logic [pkt_pkg::CNT_W-1:0]  o_drop_count
);

  logic [pkt_pkg::DATA_W-1:0] run_xor;
  logic                       accept;
  logic                       bad_sum;

  // Straight pass of the handshake and payload
  assign o_valid = i_valid;
  assign o_data  = i_data;
  assign o_last  = i_last;
  assign o_ready = i_ready;

  assign accept  = i_valid & i_ready;

  // The checksum word must equal the XOR of everything before it
  assign bad_sum = (i_data != run_xor);
  assign o_error = i_last & (bad_sum | i_error);

  // Running XOR of the current packet, cleared after its last word
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      run_xor <= '0;
    end else if (accept) begin
      if (i_last) begin
        run_xor <= '0;
      end else begin
        run_xor <= run_xor ^ i_data;
      end
    end
  end

  // One count per packet that the FIFO will drop
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_drop_count <= '0;
    end else if (accept && o_error) begin
      o_drop_count <= o_drop_count + 1'b1;
    end
  end

  // Source holds its word while the FIFO is not ready
  property p_source_hold;
    @(posedge clk) disable iff (!i_arst_n)
      (i_valid && !o_ready) |=>
        (i_valid && $stable(i_data) && $stable(i_last) && $stable(i_error));
  endproperty
  a_source_hold: assert property (p_source_hold)
    else $error("ERR: source word changed while stalled");

endmodule

// File: src/pkt_drop_fifo.sv
//-----------------------------------------------------------
// Packet-mode FIFO. Words are written as they arrive but
// only complete packets become visible to the read side.
// A last word with the error mark rewinds the write pointer
// to the end of the last good packet, dropping the packet.
// Packets must be shorter than the FIFO depth.
//-----------------------------------------------------------

`timescale 1ns/1ps

module pkt_drop_fifo (
  input  logic                       clk,
  input  logic                       i_arst_n,

  // Write side, from the checksum checker
  input  logic                       i_valid,
  input  logic [pkt_pkg::DATA_W-1:0] i_data,
  input  logic                       i_last,
  input  logic                       i_error,
  output logic                       o_ready,

  // Read side, towards the output stage
  output logic                       o_valid,
  output pkt_pkg::pkt_word_t         o_word,
  input  logic                       i_ready
);

  pkt_pkg::pkt_word_t mem [pkt_pkg::FIFO_DEPTH];

  // Pointers carry an extra wrap bit for the full test
  logic [pkt_pkg::ADDR_W:0] wr_ptr;
  logic [pkt_pkg::ADDR_W:0] good_ptr;
  logic [pkt_pkg::ADDR_W:0] rd_ptr;
  logic [pkt_pkg::ADDR_W:0] used;

  // Completed packets written and read, with wrap bit
  logic [pkt_pkg::ADDR_W:0] pkt_in_cnt;
  logic [pkt_pkg::ADDR_W:0] pkt_out_cnt;

  pkt_pkg::pkt_word_t wr_word;
  pkt_pkg::pkt_word_t head;
  logic               full;
  logic               wr_en;
  logic               rd_en;
  logic               pkt_avail;
  logic               load_out;

  assign used  = wr_ptr - rd_ptr;
  assign full  = (wr_ptr[pkt_pkg::ADDR_W] != rd_ptr[pkt_pkg::ADDR_W]) &&
                 (wr_ptr[pkt_pkg::ADDR_W-1:0] == rd_ptr[pkt_pkg::ADDR_W-1:0]);

  assign o_ready = ~full;
  assign wr_en   = i_valid & ~full;

  assign wr_word = '{data: i_data, last: i_last};

  // Storage, written for every accepted word including dropped ones
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[pkt_pkg::ADDR_W-1:0]] <= wr_word;
    end
  end

  // Write pointer with rewind on a marked last word
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr     <= '0;
      good_ptr   <= '0;
      pkt_in_cnt <= '0;
    end else if (wr_en) begin
      if (i_last && i_error) begin
        wr_ptr <= good_ptr;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_last && !i_error) begin
        good_ptr   <= wr_ptr + 1'b1;
        pkt_in_cnt <= pkt_in_cnt + 1'b1;
      end
    end
  end

  // Something committed is waiting when the packet counts differ
  assign pkt_avail = (pkt_in_cnt != pkt_out_cnt);
  assign head      = mem[rd_ptr[pkt_pkg::ADDR_W-1:0]];

  // Output register is free when empty or being taken this cycle
  assign load_out  = ~o_valid | i_ready;
  assign rd_en     = load_out & pkt_avail;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rd_ptr      <= '0;
      pkt_out_cnt <= '0;
      o_valid     <= 1'b0;
    end else begin
      if (load_out) begin
        o_valid <= pkt_avail;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
        // A packet counts as read once its last word leaves memory
        if (head.last) begin
          pkt_out_cnt <= pkt_out_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      o_word <= head;
    end
  end

  // Occupancy within the depth, commit point between read and write
  property p_ptr_order;
    @(posedge clk) disable iff (!i_arst_n)
      (used <= pkt_pkg::FIFO_DEPTH) && ((good_ptr - rd_ptr) <= used);
  endproperty
  a_ptr_order: assert property (p_ptr_order)
    else $error("ERR: FIFO pointers out of order");

  // Reads never run into words of an unfinished packet
  property p_read_committed;
    @(posedge clk) disable iff (!i_arst_n)
      rd_en |-> (rd_ptr != good_ptr);
  endproperty
  a_read_committed: assert property (p_read_committed)
    else $error("ERR: read past the last good packet");

endmodule

// File: src/pkt_out_stage.sv
//-----------------------------------------------------------
// Two-entry register stage for a valid/ready link. The
// second entry catches the word in flight when the consumer
// stalls, so o_ready comes straight from a flop.
//-----------------------------------------------------------

`timescale 1ns/1ps

module pkt_out_stage #(
  parameter type T = logic [7:0]
) (
  input  logic clk,
  input  logic i_arst_n,

  // Upstream
  input  logic i_valid,
  input  T     i_payload,
  output logic o_ready,

  // Downstream
  output logic o_valid,
  output T     o_payload,
  input  logic i_ready
);

  T     skid_payload;
  logic skid_valid;
  logic in_fire;
  logic load_out;

  // Ready only while the skid entry is empty
  assign o_ready  = ~skid_valid;
  assign in_fire  = i_valid & o_ready;
  assign load_out = ~o_valid | i_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_out) begin
      // Skid entry drains first; input is blocked while it is full
      o_valid    <= skid_valid | in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load_out) begin
      o_payload <= skid_valid ? skid_payload : i_payload;
    end
    if (o_ready) begin
      skid_payload <= i_payload;
    end
  end

  // Upstream holds its word while this stage is not ready
  property p_upstream_hold;
    @(posedge clk) disable iff (!i_arst_n)
      (i_valid && !o_ready) |=> (i_valid && $stable(i_payload));
  endproperty
  a_upstream_hold: assert property (p_upstream_hold)
    else $error("ERR: input word changed while stalled");

endmodule

// File: src/pkt_filter_top.sv
//-----------------------------------------------------------
// Packet filter top level. Chains the checksum checker, the
// dropping packet FIFO and the output register stage. Good
// packets pass unchanged, bad ones are dropped and counted.
//-----------------------------------------------------------

`timescale 1ns/1ps

module pkt_filter_top (
  input  logic                       clk,
  input  logic                       i_arst_n,

  input  logic                       i_valid,
  input  logic [pkt_pkg::DATA_W-1:0] i_data,
  input  logic                       i_last,
  input  logic                       i_error,
  output logic                       o_ready,

  output logic                       o_valid,
  output logic [pkt_pkg::DATA_W-1:0] o_data,
  output logic                       o_last,
  input  logic                       i_ready,

  output logic [pkt_pkg::CNT_W-1:0]  o_drop_count
);

  // Checker to FIFO
  logic                       chk_valid;
  logic [pkt_pkg::DATA_W-1:0] chk_data;
  logic                       chk_last;
  logic                       chk_error;
  logic                       chk_ready;

  // FIFO to output stage
  logic                       rd_valid;
  pkt_pkg::pkt_word_t         rd_word;
  logic                       rd_ready;

  pkt_pkg::pkt_word_t         out_word;

  pkt_checksum_check u_check (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_valid),
    .i_data       (i_data),
    .i_last       (i_last),
    .i_error      (i_error),
    .o_ready      (o_ready),
    .o_valid      (chk_valid),
    .o_data       (chk_data),
    .o_last       (chk_last),
    .o_error      (chk_error),
    .i_ready      (chk_ready),
    .o_drop_count (o_drop_count)
  );

  pkt_drop_fifo u_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_valid  (chk_valid),
    .i_data   (chk_data),
    .i_last   (chk_last),
    .i_error  (chk_error),
    .o_ready  (chk_ready),
    .o_valid  (rd_valid),
    .o_word   (rd_word),
    .i_ready  (rd_ready)
  );

  pkt_out_stage #(.T(pkt_pkg::pkt_word_t)) u_out (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_valid   (rd_valid),
    .i_payload (rd_word),
    .o_ready   (rd_ready),
    .o_valid   (o_valid),
    .o_payload (out_word),
    .i_ready   (i_ready)
  );

  // Split the stored word back into loose outputs
  assign o_data = out_word.data;
  assign o_last = out_word.last;

endmodule

// File: sim/tb_pkt_tasks.svh
//-----------------------------------------------------------
// Random generator and packet send tasks for the packet
// filter testbench. Included inside the testbench module.
//-----------------------------------------------------------

// One step of a linear congruential generator
function automatic logic [31:0] lcg_step(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Uniform pick in lo..hi from the packet generator
function automatic int pick_range(input int lo, input int hi);
  pkt_rng = lcg_step(pkt_rng);
  return lo + (int'(pkt_rng >> 8) % (hi - lo + 1));
endfunction

task automatic drive_idle();
  i_valid = 1'b0;
  i_last  = 1'b0;
  i_error = 1'b0;
endtask

// Holds the word until o_ready is seen high before an edge
task automatic send_word(input logic [pkt_pkg::DATA_W-1:0] data, input logic last,
                         input logic err);
  int   waited;
  logic accepted;
  waited  = 0;
  i_valid = 1'b1;
  i_data  = data;
  i_last  = last;
  i_error = err;
  do begin
    @(negedge clk);
    accepted = o_ready;
    @(posedge clk);
    #1;
    waited++;
    if (!accepted && waited > TIMEOUT) begin
      $display("Input handshake timed out in test %s", test_name);
      abort_run();
    end
  end while (!accepted);
endtask

// Body words are random, the last word is their XOR
task automatic send_packet(input int len, input logic bad_sum, input logic src_err,
                           input int gap);
  logic [pkt_pkg::DATA_W-1:0] body [$];
  logic [pkt_pkg::DATA_W-1:0] sum;
  logic                       good;
  sum  = '0;
  good = !bad_sum && !src_err;
  for (int i = 0; i < len - 1; i++) begin
    pkt_rng = lcg_step(pkt_rng);
    body.push_back(pkt_rng);
    sum = sum ^ pkt_rng;
  end
  if (bad_sum) begin
    // Nonzero flip pattern so the sum is always wrong
    pkt_rng = lcg_step(pkt_rng);
    sum = sum ^ (pkt_rng | 32'h1);
  end
  body.push_back(sum);
  if (good) begin
    foreach (body[i]) begin
      exp_q.push_back(pkt_pkg::pkt_word_t'{data: body[i], last: (i == len - 1)});
    end
    exp_total += len;
  end else begin
    exp_drops++;
  end
  for (int i = 0; i < len; i++) begin
    if (i == len - 1 && gap > 0) begin
      drive_idle();
      repeat (gap) @(posedge clk);
      #1;
    end
    send_word(body[i], (i == len - 1), (i == len - 1) && src_err);
  end
  drive_idle();
  if (good) begin
    released += len;
  end
endtask

// File: sim/tb_pkt_filter.sv
//-----------------------------------------------------------
// Testbench for the packet filter. Sends random packets,
// some with a bad checksum or a source error, under several
// consumer ready patterns. Concurrent assertions compare the
// output stream and drop count with a packet model.
//-----------------------------------------------------------

`timescale 1ns/1ps

module tb_pkt_filter;

  localparam int          TIMEOUT = 4000;
  localparam logic [31:0] SEED    = 32'h51cd_d072;

  logic                       clk;
  logic                       i_arst_n;
  logic                       i_valid;
  logic [pkt_pkg::DATA_W-1:0] i_data;
  logic                       i_last;
  logic                       i_error;
  logic                       o_ready;
  logic                       o_valid;
  logic [pkt_pkg::DATA_W-1:0] o_data;
  logic                       o_last;
  logic                       i_ready;
  logic [pkt_pkg::CNT_W-1:0]  o_drop_count;

  // Model of the good words in order, and the expected drops
  pkt_pkg::pkt_word_t        exp_q [$];
  pkt_pkg::pkt_word_t        exp_head;
  logic                      head_ok;
  logic [pkt_pkg::CNT_W-1:0] exp_drops;
  int                        exp_total;
  int                        released;
  int                        taken;
  logic                      out_fire;
  logic                      check_idle;

  // 0 always ready, 1 random at 30 percent, 2 held low
  int                        ready_mode;
  logic [31:0]               pkt_rng;
  logic [31:0]               rdy_rng;
  string                     test_name;

  pkt_filter_top uut (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_valid      (i_valid),
    .i_data       (i_data),
    .i_last       (i_last),
    .i_error      (i_error),
    .o_ready      (o_ready),
    .o_valid      (o_valid),
    .o_data       (o_data),
    .o_last       (o_last),
    .i_ready      (i_ready),
    .o_drop_count (o_drop_count)
  );

  always #4 clk = ~clk;

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_pkt_tasks.svh"

  always @(posedge clk) begin
    #1;
    case (ready_mode)
      0: i_ready = 1'b1;
      1: begin
        rdy_rng = lcg_step(rdy_rng);
        i_ready = (rdy_rng[31:24] < 8'd77);
      end
      default: i_ready = 1'b0;
    endcase
  end

  // Everything the edge will see is settled by the falling edge
  always @(negedge clk) begin
    head_ok = (taken < exp_q.size());
    if (head_ok) begin
      exp_head = exp_q[taken];
    end
    out_fire = o_valid && i_ready;
  end

  always @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      taken <= 0;
    end else if (out_fire) begin
      taken <= taken + 1;
    end
  end

  a_reset_state: assert property (@(posedge clk)
    $rose(i_arst_n) |-> (!o_valid && o_ready && o_drop_count == '0))
    else begin
      $display("ERR %s: expected valid 0 ready 1 drops 0, actual valid %0b ready %0b drops %0d",
               test_name, $sampled(o_valid), $sampled(o_ready), $sampled(o_drop_count));
      abort_run();
    end

  a_no_early: assert property (@(posedge clk) disable iff (!i_arst_n)
    o_valid |-> (taken < released))
    else begin
      $display("Output word %0d showed up before its packet was complete in test %s",
               $sampled(taken), test_name);
      abort_run();
    end

  a_out_word: assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_valid && i_ready) |->
      (head_ok && o_data == exp_head.data && o_last == exp_head.last))
    else begin
      $display("ERR %s word %0d: expected %h last %0b, actual %h last %0b",
               test_name, $sampled(taken), $sampled(exp_head.data),
               $sampled(exp_head.last), $sampled(o_data), $sampled(o_last));
      abort_run();
    end

  a_drop_count: assert property (@(posedge clk) disable iff (!i_arst_n)
    check_idle |-> (o_drop_count == exp_drops))
    else begin
      $display("ERR %s drop count: expected %0d, actual %0d",
               test_name, $sampled(exp_drops), $sampled(o_drop_count));
      abort_run();
    end

  // Drained filter takes input again and holds no extra word
  a_idle_state: assert property (@(posedge clk) disable iff (!i_arst_n)
    check_idle |-> (o_ready && !o_valid))
    else begin
      $display("ERR %s idle state: expected ready 1 valid 0, actual ready %0b valid %0b",
               test_name, $sampled(o_ready), $sampled(o_valid));
      abort_run();
    end

  // Mode changes land on the falling edge, away from the ready driver
  task automatic set_ready_mode(input int mode);
    @(negedge clk);
    ready_mode = mode;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_ready_low();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (o_ready && waited > TIMEOUT) begin
        $display("o_ready never fell under back-pressure in test %s", test_name);
        abort_run();
      end
    end while (o_ready);
  endtask

  // Wait for every model word, then pulse the idle checks
  task automatic drain_and_check();
    int waited;
    waited = 0;
    while (taken != exp_total) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("Output did not drain in test %s", test_name);
        abort_run();
      end
    end
    @(posedge clk);
    #1;
    check_idle = 1'b1;
    @(posedge clk);
    #1;
    check_idle = 1'b0;
  endtask

  initial begin
    clk        = 1'b0;
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_data     = '0;
    i_last     = 1'b0;
    i_error    = 1'b0;
    i_ready    = 1'b1;
    ready_mode = 0;
    check_idle = 1'b0;
    out_fire   = 1'b0;
    head_ok    = 1'b0;
    taken      = 0;
    exp_total  = 0;
    released   = 0;
    exp_drops  = '0;
    pkt_rng    = SEED;
    rdy_rng    = lcg_step(lcg_step(SEED));
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    i_arst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;

    test_name = "good_stream";
    repeat (8) send_packet(pick_range(2, 40), 1'b0, 1'b0, 0);
    drain_and_check();

    test_name = "bad_checksum";
    for (int n = 0; n < 9; n++) begin
      send_packet(pick_range(2, 40), (n % 3 == 1), 1'b0, 0);
    end
    drain_and_check();

    test_name = "source_error";
    for (int n = 0; n < 8; n++) begin
      send_packet(pick_range(2, 40), 1'b0, (n % 2 == 0), 0);
    end
    drain_and_check();

    test_name = "early_visibility";
    repeat (4) send_packet(pick_range(2, 20), 1'b0, 1'b0, pick_range(4, 12));
    drain_and_check();

    test_name = "random_ready";
    set_ready_mode(1);
    repeat (30) begin
      send_packet(pick_range(2, 40), (pick_range(0, 5) == 0), (pick_range(0, 5) == 0),
                  pick_range(0, 2));
    end
    drain_and_check();

    // Stall the consumer until the input side backs up
    test_name = "backpressure";
    set_ready_mode(2);
    fork
      begin
        repeat (3) send_packet(30, 1'b0, 1'b0, 0);
        send_packet(12, 1'b1, 1'b0, 0);
        send_packet(20, 1'b0, 1'b0, 0);
      end
      begin
        wait_ready_low();
        repeat (20) @(posedge clk);
        set_ready_mode(0);
      end
    join
    drain_and_check();

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: all.f
+incdir+sim
src/pkt_pkg.sv
src/pkt_checksum_check.sv
src/pkt_drop_fifo.sv
src/pkt_out_stage.sv
src/pkt_filter_top.sv
sim/tb_pkt_filter.sv

// File: Makefile
# Verilator build and run for the packet filter testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_pkt_filter
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test: passed"; \
	else \
		echo "test: failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
